// File: run_sim.sh
#!/bin/sh
# build with Verilator from the project root and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module control_path_tb -o control_path_sim \
    > build.log 2>&1 \
    && ./obj_dir/control_path_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// File: source/branch_folding.sv
`timescale 1ns/10ps

module branch_folding import control_pkg::*; #(
    parameter int THREAD_COUNT = 8
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          write_enable,
    input  logic [((THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1)-1:0] write_thread,
    input  branch_entry_t write_entry,
    input  logic [((THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1)-1:0] read_thread,
    output branch_entry_t read_entry,
    input  logic [((THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1)-1:0] thread,
    input  pc_t           pc,
    input  logic          alu_zero,
    output logic          jump,
    output pc_t           destination
);

    branch_entry_t entries [THREAD_COUNT];
    branch_entry_t current;
    logic origin_hit;
    logic cond_met;

    // cleared entries carry COND_NEVER, so nothing folds after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                entries[i] <= '0;
            end
        end else if (write_enable) begin
            entries[write_thread] <= write_entry;
        end
    end

    // bus read back
    assign read_entry = entries[read_thread];

    // entry of the thread owning this slot
    assign current = entries[thread];
    assign origin_hit = (current.origin == pc);

    always_comb begin
        case (current.cond)
            COND_ALWAYS:     cond_met = 1'b1;
            COND_ON_ZERO:    cond_met = alu_zero;
            COND_ON_NONZERO: cond_met = !alu_zero;
            default:         cond_met = 1'b0;
        endcase
    end

    // folded branch, decided in the same cycle as the pc read
    assign jump        = origin_hit && cond_met;
    assign destination = current.destination;

endmodule

// File: source/bus_pkg.sv
package bus_pkg;

    import control_pkg::*;

    localparam int WB_ADR_WIDTH = 10;
    localparam int WB_DAT_WIDTH = 32;

    // word address map
    localparam logic [WB_ADR_WIDTH-1:0] INSTR_BASE = 10'd0;
    localparam int INSTR_SPAN = 256;
    // one branch entry per thread starting here
    localparam logic [WB_ADR_WIDTH-1:0] BRANCH_BASE = 10'd256;

    // master to slave
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [WB_ADR_WIDTH-1:0] adr;
        logic [WB_DAT_WIDTH-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                    ack;
        logic [WB_DAT_WIDTH-1:0] dat;
    } wb_rsp_t;

    // a write word is read either as an instruction or as a branch entry,
    // depending on the region the address falls in
    typedef union packed {
        instr_t        instr;
        branch_entry_t branch;
    } bus_word_u;

endpackage

// File: source/bus_write_port.sv
`timescale 1ns/10ps

module bus_write_port import control_pkg::*, bus_pkg::*; #(
    parameter int THREAD_COUNT = 8
) (
    input  logic          clock,
    input  logic          reset,
    input  wb_req_t       wb_req,
    output wb_rsp_t       wb_rsp,
    output logic          imem_we,
    output pc_t           imem_addr,
    output instr_t        imem_data,
    output logic          branch_we,
    output logic [((THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1)-1:0] branch_thread,
    output branch_entry_t branch_data,
    input  branch_entry_t branch_read_data
);

    localparam int THREAD_WIDTH = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1;

    typedef enum logic {
        STATE_IDLE,
        STATE_ACK
    } state_t;

    state_t state;
    logic ack_q;
    logic [WB_DAT_WIDTH-1:0] read_q;

    logic [WB_ADR_WIDTH-1:0] instr_offset;
    logic [WB_ADR_WIDTH-1:0] branch_offset;
    logic in_instr;
    logic in_branch;
    logic accept;
    bus_word_u word;

    // region decode, offsets below a base wrap to large values and miss
    assign instr_offset  = wb_req.adr - INSTR_BASE;
    assign branch_offset = wb_req.adr - BRANCH_BASE;
    assign in_instr  = instr_offset < WB_ADR_WIDTH'(INSTR_SPAN);
    assign in_branch = branch_offset < WB_ADR_WIDTH'(THREAD_COUNT);

    // the master holds adr and dat through the ack cycle, so the write
    // address and data can be taken straight from the request
    assign word          = wb_req.dat;
    assign imem_addr     = instr_offset[PC_WIDTH-1:0];
    assign imem_data     = word.instr;
    assign branch_thread = branch_offset[THREAD_WIDTH-1:0];
    assign branch_data   = word.branch;

    assign accept = (state == STATE_IDLE) && wb_req.cyc && wb_req.stb;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= STATE_IDLE;
            ack_q     <= 1'b0;
            imem_we   <= 1'b0;
            branch_we <= 1'b0;
        end else begin
            case (state)
                STATE_IDLE: begin
                    if (accept) begin
                        state     <= STATE_ACK;
                        ack_q     <= 1'b1;
                        // stray writes are acked but touch nothing
                        imem_we   <= wb_req.we && in_instr;
                        branch_we <= wb_req.we && in_branch;
                    end
                end
                default: begin
                    ack_q     <= 1'b0;
                    imem_we   <= 1'b0;
                    branch_we <= 1'b0;
                    // stay here until stb drops, one ack per strobe
                    if (!wb_req.stb) begin
                        state <= STATE_IDLE;
                    end
                end
            endcase
        end
    end

    // only branch entries read back
    always_ff @(posedge clock) begin
        if (accept) begin
            read_q <= (!wb_req.we && in_branch) ? branch_read_data : '0;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: read_q};

    ack_needs_stb: assert property (
        @(posedge clock) disable iff (reset)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)
    );

    one_write_target: assert property (
        @(posedge clock) disable iff (reset)
        !(imem_we && branch_we)
    );

endmodule

// File: source/control_path.sv
`timescale 1ns/10ps

module control_path import control_pkg::*, bus_pkg::*; #(
    parameter int THREAD_COUNT = 8,
    parameter int I_TAP_PIPELINE_DEPTH = 1
) (
    input  logic    clock,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    input  logic    io_ready,
    input  logic    alu_zero,
    output logic [((THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1)-1:0] thread,
    output pc_t     pc,
    output instr_t  instruction
);

    localparam int THREAD_WIDTH = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1;

    logic imem_we;
    pc_t imem_addr;
    instr_t imem_data;
    logic branch_we;
    logic [THREAD_WIDTH-1:0] branch_thread;
    branch_entry_t branch_data;
    branch_entry_t branch_read_data;
    logic jump;
    pc_t destination;

    bus_write_port #(
        .THREAD_COUNT (THREAD_COUNT)
    ) u_bus_write_port (
        .clock            (clock),
        .reset            (reset),
        .wb_req           (wb_req),
        .wb_rsp           (wb_rsp),
        .imem_we          (imem_we),
        .imem_addr        (imem_addr),
        .imem_data        (imem_data),
        .branch_we        (branch_we),
        .branch_thread    (branch_thread),
        .branch_data      (branch_data),
        .branch_read_data (branch_read_data)
    );

    thread_counter #(
        .THREAD_COUNT (THREAD_COUNT)
    ) u_thread_counter (
        .clock  (clock),
        .reset  (reset),
        .thread (thread)
    );

    pc_controller #(
        .THREAD_COUNT (THREAD_COUNT)
    ) u_pc_controller (
        .clock       (clock),
        .reset       (reset),
        .thread      (thread),
        .io_ready    (io_ready),
        .jump        (jump),
        .destination (destination),
        .pc          (pc)
    );

    // bus reads and writes share one thread index
    branch_folding #(
        .THREAD_COUNT (THREAD_COUNT)
    ) u_branch_folding (
        .clock        (clock),
        .reset        (reset),
        .write_enable (branch_we),
        .write_thread (branch_thread),
        .write_entry  (branch_data),
        .read_thread  (branch_thread),
        .read_entry   (branch_read_data),
        .thread       (thread),
        .pc           (pc),
        .alu_zero     (alu_zero),
        .jump         (jump),
        .destination  (destination)
    );

    instruction_memory #(
        .I_TAP_PIPELINE_DEPTH (I_TAP_PIPELINE_DEPTH)
    ) u_instruction_memory (
        .clock        (clock),
        .reset        (reset),
        .write_enable (imem_we),
        .write_addr   (imem_addr),
        .write_data   (imem_data),
        .read_addr    (pc),
        .read_data    (instruction)
    );

endmodule

// File: source/control_pkg.sv
package control_pkg;

    // 256 instruction words, one PC per thread
    localparam int PC_WIDTH = 8;
    localparam int INSTR_WIDTH = 32;
    localparam int INSTR_DEPTH = 1 << PC_WIDTH;

    typedef logic [PC_WIDTH-1:0] pc_t;

    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // condition tested against the single alu zero flag
    typedef enum logic [1:0] {
        COND_NEVER      = 2'd0,
        COND_ALWAYS     = 2'd1,
        COND_ON_ZERO    = 2'd2,
        COND_ON_NONZERO = 2'd3
    } branch_cond_t;

    // one folded branch per thread, packed into a single bus word
    typedef struct packed {
        logic [13:0]  reserved;
        branch_cond_t cond;
        pc_t          destination;
        pc_t          origin;
    } branch_entry_t;

endpackage

// File: source/instruction_memory.sv
`timescale 1ns/10ps

module instruction_memory import control_pkg::*; #(
    parameter int I_TAP_PIPELINE_DEPTH = 1
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   write_enable,
    input  pc_t    write_addr,
    input  instr_t write_data,
    input  pc_t    read_addr,
    output instr_t read_data
);

    instr_t ram [INSTR_DEPTH];
    instr_t ram_read;

    // independent write and read ports, read is registered
    always_ff @(posedge clock) begin
        if (write_enable) begin
            ram[write_addr] <= write_data;
        end
        ram_read <= ram[read_addr];
    end

    generate
        if (I_TAP_PIPELINE_DEPTH == 0) begin : g_no_taps
            assign read_data = ram_read;
        end else begin : g_taps
            // extra stages after the ram output to break the fetch path
            instr_t taps [I_TAP_PIPELINE_DEPTH];

            always_ff @(posedge clock) begin
                if (reset) begin
                    for (int i = 0; i < I_TAP_PIPELINE_DEPTH; i++) begin
                        taps[i] <= '0;
                    end
                end else begin
                    taps[0] <= ram_read;
                    for (int i = 1; i < I_TAP_PIPELINE_DEPTH; i++) begin
                        taps[i] <= taps[i-1];
                    end
                end
            end

            assign read_data = taps[I_TAP_PIPELINE_DEPTH-1];
        end
    endgenerate

endmodule

// File: source/pc_controller.sv
`timescale 1ns/10ps

module pc_controller import control_pkg::*; #(
    parameter int THREAD_COUNT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic [((THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1)-1:0] thread,
    input  logic io_ready,
    input  logic jump,
    input  pc_t  destination,
    output pc_t  pc
);

    pc_t pc_mem [THREAD_COUNT];
    pc_t next_pc;

    // current thread's pc is visible in its own slot
    assign pc = pc_mem[thread];

    always_comb begin
        if (!io_ready) begin
            // replay the same instruction
            next_pc = pc;
        end else if (jump) begin
            next_pc = destination;
        end else begin
            // wraps at 256
            next_pc = pc + 1'b1;
        end
    end

    // written back at the end of the slot
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                pc_mem[i] <= '0;
            end
        end else begin
            pc_mem[thread] <= next_pc;
        end
    end

    // a stalled slot leaves that thread's stored pc unchanged
    stall_holds_pc: assert property (
        @(posedge clock) disable iff (reset)
        !io_ready |=> (pc_mem[$past(thread)] == $past(pc))
    );

endmodule

// File: source/thread_counter.sv
`timescale 1ns/10ps

module thread_counter #(
    parameter int THREAD_COUNT = 8
) (
    input  logic clock,
    input  logic reset,
    output logic [((THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1)-1:0] thread
);

    localparam int THREAD_WIDTH = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1;
    localparam logic [THREAD_WIDTH-1:0] LAST_THREAD = THREAD_WIDTH'(THREAD_COUNT - 1);

    // one slot per cycle in strict round robin
    always_ff @(posedge clock) begin
        if (reset) begin
            thread <= '0;
        end else if (thread == LAST_THREAD) begin
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

    // the per-thread tables downstream hold only THREAD_COUNT entries
    thread_in_range: assert property (
        @(posedge clock) disable iff (reset)
        int'(thread) < THREAD_COUNT
    );

endmodule

// File: testbench/control_path_tb.sv
`timescale 1ns/10ps

module control_path_tb import control_pkg::*, bus_pkg::*; #(
    parameter int THREAD_COUNT = 8,
    parameter int TAP_DEPTH = 1
) ();

    localparam int THREAD_WIDTH = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1;
    localparam int TIMEOUT_CYCLES = 20;

    // expected fetch word and whether it is worth comparing
    typedef struct packed {
        logic   valid;
        instr_t word;
    } fetch_t;

    logic clock;
    logic reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic io_ready;
    logic alu_zero;
    logic [THREAD_WIDTH-1:0] thread;
    pc_t pc;
    instr_t instruction;

    // reference model state
    instr_t model_imem [256];
    branch_entry_t model_branch [THREAD_COUNT];
    pc_t model_pc [THREAD_COUNT];
    int model_thread;
    fetch_t fetch_queue [$];

    logic fetch_check;
    int io_mode;
    int error_count;
    int check_count;
    int fold_count;
    int ack_count;
    int bus_cycles;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (reset)
    );

    control_path #(
        .THREAD_COUNT         (THREAD_COUNT),
        .I_TAP_PIPELINE_DEPTH (TAP_DEPTH)
    ) DUT (
        .clock       (clock),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .io_ready    (io_ready),
        .alu_zero    (alu_zero),
        .thread      (thread),
        .pc          (pc),
        .instruction (instruction)
    );

    task automatic report_value(string name, logic [31:0] expected, logic [31:0] actual);
        error_count++;
        $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    function automatic logic cond_holds(branch_cond_t cond, logic zero);
        case (cond)
            COND_ALWAYS:     return 1'b1;
            COND_ON_ZERO:    return zero;
            COND_ON_NONZERO: return !zero;
            default:         return 1'b0;
        endcase
    endfunction

    // one barrel slot of the model, compared with the DUT
    task automatic check_slot();
        int t;
        pc_t cur;
        pc_t nxt;
        branch_entry_t entry;
        fetch_t oldest;
        fetch_t newest;
        t = model_thread;
        cur = model_pc[t];
        entry = model_branch[t];
        check_count++;
        if (thread !== THREAD_WIDTH'(t)) begin
            report_value("thread", t, 32'(thread));
        end
        if (pc !== cur) begin
            report_value("pc", 32'(cur), 32'(pc));
        end
        // word fetched 1 + TAP_DEPTH slots ago
        if (fetch_queue.size() == TAP_DEPTH + 1) begin
            oldest = fetch_queue.pop_front();
            if (oldest.valid && instruction !== oldest.word) begin
                report_value("instruction", oldest.word, instruction);
            end
        end
        newest.valid = fetch_check;
        newest.word = model_imem[cur];
        fetch_queue.push_back(newest);
        if (!io_ready) begin
            nxt = cur;
        end else if (entry.origin == cur && cond_holds(entry.cond, alu_zero)) begin
            nxt = entry.destination;
            fold_count++;
        end else begin
            nxt = cur + 8'd1;
        end
        model_pc[t] = nxt;
        model_thread = (t + 1) % THREAD_COUNT;
        // a bus write lands at the end of the ack cycle, after this slot
        if (wb_rsp.ack) begin
            ack_count++;
            if (wb_req.we && wb_req.adr < 10'd256) begin
                model_imem[wb_req.adr[7:0]] = wb_req.dat;
            end else if (wb_req.we && int'(wb_req.adr) < 256 + THREAD_COUNT) begin
                model_branch[int'(wb_req.adr) - 256] = wb_req.dat;
            end
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            model_thread = 0;
            fetch_queue.delete();
            for (int t = 0; t < THREAD_COUNT; t++) begin
                model_pc[t] = '0;
                model_branch[t] = '0;
            end
        end else begin
            check_slot();
        end
    end

    // io_ready held low, held high or random per slot
    always @(posedge clock) begin
        #1;
        alu_zero = 1'($urandom_range(0, 1));
        if (io_mode == 0) begin
            io_ready = 1'b0;
        end else if (io_mode == 1) begin
            io_ready = 1'b1;
        end else begin
            io_ready = 1'($urandom_range(0, 1));
        end
    end

    task automatic bus_cycle(input logic write, input logic [9:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        int waited;
        @(posedge clock);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: dat};
        waited = 0;
        rdata = '0;
        @(negedge clock);
        while (!wb_rsp.ack && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clock);
        end
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat;
            bus_cycles++;
        end else begin
            error_count++;
            $display("bus cycle to address %0h got no ack within %0d cycles", adr, waited);
        end
        @(posedge clock);
        #1;
        wb_req = '0;
        // the slave must stay quiet once stb is gone
        @(negedge clock);
        if (wb_rsp.ack) begin
            error_count++;
            $display("bus cycle to address %0h was acked a second time", adr);
        end
    endtask

    initial begin
        int i;
        int waited;
        logic [31:0] rdata;
        branch_entry_t entry;
        void'($urandom(36));
        wb_req = '0;
        io_ready = 1'b0;
        alu_zero = 1'b0;
        io_mode = 0;
        fetch_check = 1'b0;
        error_count = 0;
        check_count = 0;
        fold_count = 0;
        ack_count = 0;
        bus_cycles = 0;
        waited = 0;
        while (reset !== 1'b0 && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge clock);
        end
        if (reset !== 1'b0) begin
            error_count++;
            $display("reset was never released");
        end
        // loading with io_ready low, every thread stays parked at pc 0
        for (i = 0; i < 256; i++) begin
            bus_cycle(1'b1, 10'(i), $urandom(), rdata);
        end
        for (i = 0; i < THREAD_COUNT; i++) begin
            entry = $urandom();
            entry.cond = COND_NEVER;
            bus_cycle(1'b1, 10'(256 + i), entry, rdata);
        end
        for (i = 0; i < THREAD_COUNT; i++) begin
            bus_cycle(1'b0, 10'(256 + i), '0, rdata);
            if (rdata !== 32'(model_branch[i])) begin
                report_value("wb_rsp.dat", 32'(model_branch[i]), rdata);
            end
        end
        bus_cycle(1'b0, 10'($urandom_range(0, 255)), '0, rdata);
        if (rdata !== '0) begin
            report_value("wb_rsp.dat", 32'd0, rdata);
        end
        // sequential fetch long enough for every pc to wrap
        @(posedge clock);
        fetch_check = 1'b1;
        io_mode = 1;
        repeat (THREAD_COUNT * 260) @(posedge clock);
        // live branch entries with origins a few slots ahead
        for (i = 0; i < THREAD_COUNT; i++) begin
            entry = $urandom();
            entry.origin = model_pc[i] + 8'($urandom_range(8, 40));
            bus_cycle(1'b1, 10'(256 + i), entry, rdata);
        end
        repeat (800) @(posedge clock);
        if (fold_count == 0) begin
            error_count++;
            $display("no branch was folded while branch entries were active");
        end
        // random stalls on top of folding
        io_mode = 2;
        repeat (800) @(posedge clock);
        if (ack_count != bus_cycles) begin
            report_value("ack count", bus_cycles, ack_count);
        end
        $display("slots checked: %0d, folds: %0d, errors: %0d",
                 check_count, fold_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // synchronous reset, released just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

// File: verilog.f
source/control_pkg.sv
source/bus_pkg.sv
source/thread_counter.sv
source/bus_write_port.sv
source/instruction_memory.sv
source/branch_folding.sv
source/pc_controller.sv
source/control_path.sv
testbench/tb_clock_gen.sv
testbench/control_path_tb.sv
